//--- hmac_defs.svh
`ifndef HMAC_DEFS_SVH
`define HMAC_DEFS_SVH

// APB address width
`define HMAC_ADDR_W       8

// Key and digest sizes in 32-bit words
`define HMAC_KEY_WORDS    16
`define HMAC_DIGEST_WORDS 8

// Register map
`define HMAC_REG_CTRL     8'h00 // Command on write, status on read
`define HMAC_REG_DATA     8'h04 // Message word port
`define HMAC_REG_KEY      8'h40 // 16 key words, first word is MSB of key
`define HMAC_REG_DIGEST   8'h80 // 8 digest words, read only

`endif

//--- hmac_pkg.sv
`default_nettype none

package hmac_pkg;
`include "hmac_defs.svh"

	// APB4 master to slave
	typedef struct packed {
		logic [`HMAC_ADDR_W-1:0] paddr;
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [31:0]             pwdata;
		logic [3:0]              pstrb;
	} apb_req_t;

	// APB4 slave to master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// One word into a hasher, big-endian
	typedef struct packed {
		logic        update;   // Data word valid
		logic        finalize; // End of message
		logic [31:0] data;
		logic [2:0]  nbytes;   // Leading bytes valid, 1..4
	} hash_beat_t;

	////////////////////
	// CTRL word, two views

	typedef struct packed {
		logic [28:0] reserved;
		logic        key_load; // bit 2
		logic        finalize; // bit 1
		logic        start;    // bit 0
	} hmac_cmd_t;

	typedef struct packed {
		logic [28:0] reserved;
		logic        done;  // bit 2
		logic        busy;  // bit 1
		logic        ready; // bit 0
	} hmac_status_t;

	typedef union packed {
		hmac_cmd_t    cmd;    // Write view
		hmac_status_t status; // Read view
	} hmac_ctrl_u;

endpackage

`default_nettype wire

//--- sha256_compress.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_compress (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         blk_start,
	input  logic [511:0] block,
	input  logic [255:0] chain_in,
	output logic         blk_done,
	output logic [255:0] chain_out
);

	localparam logic [31:0] K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		rotr = (x >> n) | (x << (32 - n));
	endfunction

	////////////////////
	// Round state

	logic [31:0] w [0:15];            // Rolling schedule, w[0] is W_t
	logic [31:0] a, b, c, d, e, f, g, h;
	logic [5:0]  rnd;
	logic        busy;

	logic [31:0] s0, s1, ch, maj, t1, t2, w_next;

	always_comb begin
		s1     = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);
		ch     = (e & f) ^ (~e & g);
		t1     = h + s1 + ch + K[rnd] + w[0];
		s0     = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
		maj    = (a & b) ^ (a & c) ^ (b & c);
		t2     = s0 + maj;
		// W_{t+16} from the window
		w_next = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
			+ (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	// Control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			rnd      <= '0;
			blk_done <= 1'b0;
		end else begin
			blk_done <= 1'b0;
			if (blk_start) begin
				busy <= 1'b1;
				rnd  <= '0;
			end else if (busy) begin
				rnd <= rnd + 6'd1;
				if (rnd == 6'd63) begin
					busy     <= 1'b0;
					blk_done <= 1'b1; // 65 cycles after blk_start
				end
			end
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (blk_start) begin
			for (int i = 0; i < 16; i++) begin
				w[i] <= block[511 - 32*i -: 32]; // First word at MSB
			end
			{a, b, c, d, e, f, g, h} <= chain_in;
		end else if (busy) begin
			for (int i = 0; i < 15; i++) begin
				w[i] <= w[i+1];
			end
			w[15] <= w_next;
			h <= g;
			g <= f;
			f <= e;
			e <= d + t1;
			d <= c;
			c <= b;
			b <= a;
			a <= t1 + t2;
			if (rnd == 6'd63) begin
				// Fold last round into the chain
				chain_out <= {chain_in[255:224] + t1 + t2, chain_in[223:192] + a,
					chain_in[191:160] + b, chain_in[159:128] + c,
					chain_in[127:96] + d + t1, chain_in[95:64] + e,
					chain_in[63:32] + f, chain_in[31:0] + g};
			end
		end
	end

endmodule

`default_nettype wire

//--- sha256_stream.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_stream import hmac_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  hash_beat_t   beat,
	output logic         accept,
	output logic         hash_valid,
	output logic [255:0] hash
);

	localparam logic [255:0] IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_COMP, S_LEN} state_t;

	// Keep leading nbytes of a word, zero the rest
	function automatic logic [31:0] keep_mask(input logic [2:0] n);
		case (n)
			3'd1:    keep_mask = 32'hff00_0000;
			3'd2:    keep_mask = 32'hffff_0000;
			3'd3:    keep_mask = 32'hffff_ff00;
			default: keep_mask = 32'hffff_ffff;
		endcase
	endfunction

	state_t       state;
	logic [511:0] blk;        // Block buffer
	logic [5:0]   bcnt;       // Bytes in buffer
	logic [63:0]  len;        // Message length in bits
	logic [255:0] h_q;        // Chaining value
	logic         fin, last;
	logic         blk_start, blk_done;
	logic [255:0] chain_out;
	logic [6:0]   nxt;

	assign nxt    = {1'b0, bcnt} + {4'd0, beat.nbytes};
	assign accept = (state == S_LOAD);

	sha256_compress comp_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.blk_start (blk_start),
		.block     (blk),
		.chain_in  (h_q),
		.blk_done  (blk_done),
		.chain_out (chain_out)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			bcnt       <= '0;
			len        <= '0;
			fin        <= 1'b0;
			last       <= 1'b0;
			blk_start  <= 1'b0;
			hash_valid <= 1'b0;
		end else begin
			blk_start  <= 1'b0;
			hash_valid <= 1'b0;
			if (start) begin
				state <= S_LOAD;
				h_q   <= IV;
				blk   <= '0;
				bcnt  <= '0;
				len   <= '0;
				fin   <= 1'b0;
				last  <= 1'b0;
			end else begin
				case (state)
					S_LOAD: begin
						if (beat.update) begin
							// Word aligned, only the last word can be short
							blk[511 - 32*bcnt[5:2] -: 32] <= beat.data & keep_mask(beat.nbytes);
							bcnt <= nxt[5:0];
							len  <= len + {58'd0, beat.nbytes, 3'd0};
							if (nxt[6]) begin // Block full
								blk_start <= 1'b1;
								state     <= S_COMP;
							end
						end else if (beat.finalize) begin
							blk[511 - 8*bcnt -: 8] <= 8'h80;
							fin       <= 1'b1;
							blk_start <= 1'b1;
							state     <= S_COMP;
							if (bcnt < 6'd56) begin // Length fits here
								blk[63:0] <= len;
								last      <= 1'b1;
							end
						end
					end
					S_COMP: begin
						if (blk_done) begin
							h_q  <= chain_out;
							blk  <= '0;
							bcnt <= '0;
							if (last) begin
								hash       <= chain_out;
								hash_valid <= 1'b1;
								state      <= S_IDLE;
							end else if (fin) begin
								state <= S_LEN; // Extra length block
							end else begin
								state <= S_LOAD;
							end
						end
					end
					S_LEN: begin
						blk[63:0] <= len;
						last      <= 1'b1;
						blk_start <= 1'b1;
						state     <= S_COMP;
					end
					default: ; // Idle until start
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hmac_sha256.sv
`timescale 1ns/1ps
`default_nettype none
`include "hmac_defs.svh"

module hmac_sha256 import hmac_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         key_update,
	input  logic [511:0] key,
	input  logic         start,
	input  hash_beat_t   msg,
	output logic         ready,
	output logic         accept,
	output logic         hash_valid,
	output logic [255:0] hash
);

	typedef enum logic [2:0] {
		S_IDLE, S_IN_PAD, S_MSG, S_IN_WAIT, S_OUT_PAD, S_REHASH, S_FINALIZE, S_OUT_WAIT
	} state_t;

	function automatic hash_beat_t full_word(input logic [31:0] w);
		full_word = '{update: 1'b1, finalize: 1'b0, data: w, nbytes: 3'd4};
	endfunction

	////////////////////
	// Key pads

	logic [511:0] ipad, opad;

	always_ff @(posedge clk) begin
		if (key_update) begin
			ipad <= key ^ {64{8'h36}};
			opad <= key ^ {64{8'h5c}};
		end
	end

	////////////////////
	// Stream hasher

	hash_beat_t   beat_q;        // Held until accepted
	logic         s_start, s_accept, s_hash_valid;
	logic [255:0] s_hash, inner;
	logic         taken, free;
	state_t       state;
	logic [4:0]   count;

	assign taken  = s_accept & (beat_q.update | beat_q.finalize);
	assign free   = ~(beat_q.update | beat_q.finalize) | taken; // Slot open next cycle
	assign ready  = (state == S_MSG);
	assign accept = ready & free;

	sha256_stream stream_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (s_start),
		.beat       (beat_q),
		.accept     (s_accept),
		.hash_valid (s_hash_valid),
		.hash       (s_hash)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			count      <= '0;
			beat_q     <= '0;
			s_start    <= 1'b0;
			hash_valid <= 1'b0;
		end else begin
			s_start    <= 1'b0;
			hash_valid <= 1'b0;
			if (taken) begin
				beat_q.update   <= 1'b0;
				beat_q.finalize <= 1'b0;
			end
			case (state)
				S_IDLE: if (start) begin
					s_start <= 1'b1;
					count   <= '0;
					state   <= S_IN_PAD;
				end
				S_IN_PAD: if (free) begin
					if (count == 5'(`HMAC_KEY_WORDS)) begin
						state <= S_MSG; // All 16 pad beats taken
					end else begin
						beat_q <= full_word(ipad[511 - 32*count[3:0] -: 32]);
						count  <= count + 5'd1;
					end
				end
				S_MSG: if (accept && (msg.update || msg.finalize)) begin
					beat_q <= msg;
					if (msg.finalize) state <= S_IN_WAIT;
				end
				S_IN_WAIT: if (s_hash_valid) begin
					inner   <= s_hash;
					s_start <= 1'b1;
					count   <= '0;
					state   <= S_OUT_PAD;
				end
				S_OUT_PAD: if (free) begin
					if (count == 5'(`HMAC_KEY_WORDS)) begin
						count <= '0;
						state <= S_REHASH;
					end else begin
						beat_q <= full_word(opad[511 - 32*count[3:0] -: 32]);
						count  <= count + 5'd1;
					end
				end
				S_REHASH: if (free) begin // Inner digest, first word at MSB
					if (count == 5'(`HMAC_DIGEST_WORDS)) begin
						state <= S_FINALIZE;
					end else begin
						beat_q <= full_word(inner[255 - 32*count[2:0] -: 32]);
						count  <= count + 5'd1;
					end
				end
				S_FINALIZE: if (free) begin
					beat_q <= '{update: 1'b0, finalize: 1'b1, data: 32'd0, nbytes: 3'd0};
					state  <= S_OUT_WAIT;
				end
				S_OUT_WAIT: if (s_hash_valid) begin
					hash       <= s_hash;
					hash_valid <= 1'b1;
					state      <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hmac_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "hmac_defs.svh"

module hmac_apb_regs import hmac_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  apb_req_t     apb_req,
	input  logic         ready,
	input  logic         accept,
	input  logic         hash_valid,
	input  logic [255:0] hash,
	output apb_rsp_t     apb_rsp,
	output logic [511:0] key,
	output logic         key_update,
	output logic         start,
	output hash_beat_t   msg,
	output logic         irq
);

	////////////////////
	// Address decode

	logic [`HMAC_ADDR_W-1:0] addr;
	logic access, aligned, is_ctrl, is_data, is_key, is_dig, mapped;
	logic data_ok, data_wr, err, wr_fire;
	logic fin_pend, busy_q, done_q;
	logic [255:0] dig_q;
	hmac_ctrl_u wr_view, rd_view;
	logic [2:0] nbytes;

	assign addr    = apb_req.paddr;
	assign access  = apb_req.psel & apb_req.penable;
	assign aligned = (addr[1:0] == 2'b00);
	assign is_ctrl = (addr == `HMAC_REG_CTRL);
	assign is_data = (addr == `HMAC_REG_DATA);
	assign is_key  = aligned && addr >= `HMAC_REG_KEY
		&& addr < `HMAC_REG_KEY + 4*`HMAC_KEY_WORDS;
	assign is_dig  = aligned && addr >= `HMAC_REG_DIGEST
		&& addr < `HMAC_REG_DIGEST + 4*`HMAC_DIGEST_WORDS;
	assign mapped  = is_ctrl | is_data | is_key | is_dig;

	assign data_ok = ready & ~fin_pend;                 // Message phase open
	assign data_wr = apb_req.pwrite & is_data;
	assign err     = ~mapped | (data_wr & ~data_ok) | (apb_req.pwrite & is_dig);
	assign wr_fire = access & apb_req.pwrite & apb_rsp.pready & ~err;
	assign wr_view = apb_req.pwdata;                    // Command view of CTRL

	// Leading set strobes, lane 3 is the first byte
	always_comb begin
		casez (apb_req.pstrb)
			4'b10??: nbytes = 3'd1;
			4'b110?: nbytes = 3'd2;
			4'b1110: nbytes = 3'd3;
			default: nbytes = 3'd4;
		endcase
	end

	// Beat to core, held by the stalled APB access
	assign msg.update   = access & data_wr & data_ok;
	assign msg.finalize = fin_pend;
	assign msg.data     = apb_req.pwdata;
	assign msg.nbytes   = nbytes;

	////////////////////
	// Response

	always_comb begin
		rd_view        = '0;
		rd_view.status.ready = ready;
		rd_view.status.busy  = busy_q;
		rd_view.status.done  = done_q;
		apb_rsp.prdata = '0;
		if (is_ctrl) apb_rsp.prdata = rd_view;
		else if (is_key) apb_rsp.prdata = key[511 - 32*addr[5:2] -: 32];
		else if (is_dig) apb_rsp.prdata = dig_q[255 - 32*addr[4:2] -: 32];
		// DATA write waits for the core
		apb_rsp.pready  = access & ~(data_wr & data_ok & ~accept);
		apb_rsp.pslverr = access & err;
	end

	assign irq = done_q;

	// Payload registers
	always_ff @(posedge clk) begin
		if (wr_fire && is_key) key[511 - 32*addr[5:2] -: 32] <= apb_req.pwdata;
		if (hash_valid) dig_q <= hash;
	end

	// Control and status
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start      <= 1'b0;
			key_update <= 1'b0;
			fin_pend   <= 1'b0;
			busy_q     <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			start      <= wr_fire & is_ctrl & wr_view.cmd.start;
			key_update <= wr_fire & is_ctrl & wr_view.cmd.key_load;
			if (fin_pend && accept) fin_pend <= 1'b0; // Core took finalize
			if (wr_fire && is_ctrl && wr_view.cmd.finalize && ready) fin_pend <= 1'b1;
			if (hash_valid) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
			if (wr_fire && is_ctrl && wr_view.cmd.start) begin
				busy_q   <= 1'b1;
				done_q   <= 1'b0;
				fin_pend <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hmac_top.sv
`timescale 1ns/1ps
`default_nettype none

module hmac_top import hmac_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic     irq
);

	logic [511:0] key;
	logic         key_update, start, ready, accept, hash_valid;
	logic [255:0] hash;
	hash_beat_t   msg;

	hmac_apb_regs regs_i (
		.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .ready(ready), .accept(accept),
		.hash_valid(hash_valid), .hash(hash), .apb_rsp(apb_rsp), .key(key),
		.key_update(key_update), .start(start), .msg(msg), .irq(irq)
	);

	hmac_sha256 core_i (
		.clk(clk), .rst_n(rst_n), .key_update(key_update), .key(key), .start(start),
		.msg(msg), .ready(ready), .accept(accept), .hash_valid(hash_valid), .hash(hash)
	);

endmodule

`default_nettype wire

//--- tb_hmac_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "hmac_defs.svh"

module tb_hmac_top import hmac_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RUNS       = 5;   // Case 1, case 2 twice, case 4, case 1 after errors
	localparam int RUN_CYCLES = 600; // Rough cycle budget of one MAC run
	localparam int WAIT_LIMIT = 400; // Cycles allowed for any single handshake

	// RFC 4231 vectors with the first byte at the MSB
	localparam logic [511:0] KEY1 = {{20{8'h0b}}, 352'd0};
	localparam logic [511:0] MSG1 = {"Hi There", 448'd0};
	localparam logic [255:0] MAC1 =
		256'hb0344c61d8db38535ca8afceaf0bf12b881dc200c9833da726e9376c2e32cff7;
	localparam logic [511:0] KEY2 = {"Jefe", 480'd0};
	localparam logic [511:0] MSG2 = {"what do ya want for nothing?", 288'd0};
	localparam logic [255:0] MAC2 =
		256'h5bdcc146bf60754e6a042426089575c75a003f089d2739839dec58b964ec3843;
	localparam logic [511:0] KEY4 =
		{200'h0102030405060708090a0b0c0d0e0f10111213141516171819, 312'd0};
	localparam logic [511:0] MSG4 = {{50{8'hcd}}, 112'd0};
	localparam logic [255:0] MAC4 =
		256'h82558a389a443c0ea4cc819899f2083a85f0faa3e578f8077a2e3ff46729665b;

	logic     clk;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     irq;

	integer seed;
	logic   gaps_on;       // Random idle cycles between transfers
	int     stall_cycles;  // DATA access cycles with pready low
	int     data_beats;    // Message beats the core took
	int     errors;

	hmac_top dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.irq     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog at twice the budget of all runs
	initial begin
		#(2 * RUNS * RUN_CYCLES * CLK_PERIOD);
		fail_now("Watchdog expired, the simulation ran far too long");
	end

	// One count per beat handshake into the core
	always @(negedge clk) begin
		if (dut_i.msg.update && dut_i.accept) data_beats++;
	end

	////////////////////
	// Bus protocol checks

	assert property (@(posedge clk) disable iff (!rst_n) !apb_rsp.pslverr || apb_rsp.pready)
		else fail_now("pslverr was high outside a completing transfer");

	assert property (@(posedge clk) disable iff (!rst_n)
		!apb_rsp.pready || (apb_req.psel && apb_req.penable))
		else fail_now("pready was high outside an access phase");

	////////////////////
	// Helpers

	task automatic fail_now(input string what);
		errors++;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act == exp)
			else fail_now($sformatf("FAIL %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic check_mac(input string test, input logic [255:0] exp,
		input logic [255:0] act);
		assert (act == exp)
			else fail_now($sformatf("FAIL %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic idle_gap();
		int n;
		n = 0;
		if (gaps_on) n = $unsigned($random(seed)) % 3;
		repeat (n) @(posedge clk);
	endtask

	// Setup phase then access phase until pready
	task automatic apb_xfer(input logic [7:0] addr, input logic write,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk);
		apb_req.paddr   <= addr;
		apb_req.pwrite  <= write;
		apb_req.pwdata  <= wdata;
		apb_req.pstrb   <= strb;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		@(posedge clk);
		apb_req.penable <= 1'b1; // Access phase
		@(negedge clk);
		while (!apb_rsp.pready) begin
			if (write && addr == `HMAC_REG_DATA) stall_cycles++; // Core back-pressure
			waits++;
			if (waits > WAIT_LIMIT) fail_now("An APB transfer never completed");
			@(negedge clk);
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk); // Transfer completes here
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic write_reg(input string test, input logic [7:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb);
		logic [31:0] unused;
		logic        err;
		idle_gap();
		apb_xfer(addr, 1'b1, wdata, strb, unused, err);
		assert (!err)
			else fail_now($sformatf("%s: write to %h got an error response", test, addr));
	endtask

	task automatic read_reg(input string test, input logic [7:0] addr,
		output logic [31:0] rdata);
		logic err;
		idle_gap();
		apb_xfer(addr, 1'b0, 32'd0, 4'h0, rdata, err);
		assert (!err)
			else fail_now($sformatf("%s: read from %h got an error response", test, addr));
	endtask

	// Access that must end with pslverr
	task automatic expect_error(input string test, input logic [7:0] addr, input logic write);
		logic [31:0] unused;
		logic        err;
		idle_gap();
		apb_xfer(addr, write, 32'hdead_beef, write ? 4'hf : 4'h0, unused, err);
		assert (err)
			else fail_now($sformatf("%s: access to %h completed without pslverr", test, addr));
	endtask

	task automatic load_key(input string test, input logic [511:0] key);
		for (int i = 0; i < `HMAC_KEY_WORDS; i++) begin
			write_reg(test, `HMAC_REG_KEY + 8'(4 * i), key[511 - 32*i -: 32], 4'hf);
		end
		write_reg(test, `HMAC_REG_CTRL, 32'h4, 4'hf); // key_load
	endtask

	// Start, stream the message, finalize, read back the MAC
	task automatic run_mac(input string test, input logic [511:0] msg, input int nbytes,
		output logic [255:0] mac);
		logic [31:0] st;
		int          polls;
		int          left;
		write_reg(test, `HMAC_REG_CTRL, 32'h1, 4'hf); // start
		polls = 0;
		do begin // Inner pad goes first
			read_reg(test, `HMAC_REG_CTRL, st);
			polls++;
			if (polls > WAIT_LIMIT) fail_now("The core never opened the message phase");
		end while (!st[0]);
		check_word({test, "_open"}, 32'h3, st); // ready and busy, done cleared
		assert (!irq)
			else fail_now($sformatf("%s: irq still high after start", test));
		for (int w = 0; 4*w < nbytes; w++) begin
			left = nbytes - 4*w;
			write_reg(test, `HMAC_REG_DATA, msg[511 - 32*w -: 32],
				left >= 4 ? 4'hf : 4'(32'hf << (4 - left))); // Leading bytes only
		end
		write_reg(test, `HMAC_REG_CTRL, 32'h2, 4'hf); // finalize
		polls = 0;
		@(negedge clk);
		while (!irq) begin
			polls++;
			if (polls > WAIT_LIMIT) fail_now("The done interrupt never rose");
			@(negedge clk);
		end
		read_reg(test, `HMAC_REG_CTRL, st);
		check_word({test, "_status"}, 32'h4, st); // done only
		for (int i = 0; i < `HMAC_DIGEST_WORDS; i++) begin
			read_reg(test, `HMAC_REG_DIGEST + 8'(4 * i), st);
			mac[255 - 32*i -: 32] = st;
		end
	endtask

	////////////////////
	// Test sequence

	initial begin
		logic [31:0]  st;
		logic [255:0] mac;
		seed         = 57102;
		apb_req      = '0;
		rst_n        = 1'b0;
		gaps_on      = 1'b1;
		stall_cycles = 0;
		data_beats   = 0;
		errors       = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Idle after reset
		@(negedge clk);
		assert (!apb_rsp.pready && !apb_rsp.pslverr && !irq)
			else fail_now("Bus response or irq not idle after reset");
		read_reg("reset", `HMAC_REG_CTRL, st);
		check_word("reset_status", 32'h0, st);

		load_key("rfc4231_case1", KEY1);
		run_mac("rfc4231_case1", MSG1, 8, mac);
		check_mac("rfc4231_case1", MAC1, mac);

		// Second run reuses the stored pads
		load_key("rfc4231_case2", KEY2);
		run_mac("rfc4231_case2", MSG2, 28, mac);
		check_mac("rfc4231_case2", MAC2, mac);
		run_mac("rfc4231_case2_again", MSG2, 28, mac);
		check_mac("rfc4231_case2_again", MAC2, mac);

		// Back to back writes with a two-byte last word
		gaps_on      = 1'b0;
		stall_cycles = 0;
		data_beats   = 0;
		load_key("rfc4231_case4", KEY4);
		run_mac("rfc4231_case4", MSG4, 50, mac);
		check_mac("rfc4231_case4", MAC4, mac);
		check_word("rfc4231_case4_beats", 32'd13, 32'(data_beats));
		assert (stall_cycles > 0)
			else fail_now("DATA writes never saw pready low, no back-pressure reached");
		gaps_on = 1'b1;

		// Error responses
		expect_error("data_before_start", `HMAC_REG_DATA, 1'b1);
		expect_error("digest_write", `HMAC_REG_DIGEST, 1'b1);
		read_reg("digest_write", `HMAC_REG_DIGEST, st);
		check_word("digest_unchanged", MAC4[255:224], st);
		expect_error("unmapped_write", 8'h08, 1'b1);
		expect_error("unmapped_read", 8'hc0, 1'b0);

		load_key("rfc4231_case1_after_errors", KEY1);
		run_mac("rfc4231_case1_after_errors", MSG1, 8, mac);
		check_mac("rfc4231_case1_after_errors", MAC1, mac);

		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
hmac_pkg.sv
sha256_compress.sv
sha256_stream.sv
hmac_sha256.sv
hmac_apb_regs.sv
hmac_top.sv
tb_hmac_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the HMAC-SHA-256 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_hmac_top \
	|| { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vtb_hmac_top 2>&1)
echo "$out"

# Pass only if the testbench printed its pass line
echo "$out" | grep -qx "Done: no errors" && exit 0 || exit 1
